/* build.f */
+incdir+hdl
hdl/qs_pkg.sv
hdl/qs_count.sv
hdl/qs_mem.sv
hdl/qs_stack.sv
hdl/qs_fsm.sv
hdl/qs_top.sv
dv/qs_checker.sv
dv/tb_qs.sv

/* Makefile */
# Verilator flow for the quicksort engine
# Targets: lint, sim (default) and clean

VERILATOR ?= verilator
TOP       ?= tb_qs
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
# The testbench ends the run itself on the first failed assertion
SIM_ARGS  ?= +verilator+error+limit+100
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_qs.sv */
// --------------------------------------------------------------------------
// Testbench for the quicksort engine
// Clock and reset, LCG packet generator, packet send and wait tasks with
// timeouts, checker binding and the end-of-run verdict
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module tb_qs;

  // Longest any single wait may take in clock cycles
  localparam int timeout_cycles = 4000;
  localparam int num_random = 40;
  localparam int buf_len = `QS_N + 3;

  // Fill patterns of the packet buffer
  localparam int fill_rand = 0;
  localparam int fill_up = 1;
  localparam int fill_down = 2;
  localparam int fill_same = 3;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             in_vld;
  logic             in_sop;
  logic             in_eop;
  logic [`QS_W-1:0] in_dat;
  logic             in_rdy;
  logic             out_vld_r;
  logic             out_sop_r;
  logic             out_eop_r;
  logic             out_err_r;
  logic [`QS_W-1:0] out_dat_r;

  logic [31:0]      lcg_state = 32'h8d4b_bcba;
  logic [`QS_W-1:0] pkt [buf_len];
  int               n;

  always #50 clk = ~clk;

  qs_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .in_rdy    (in_rdy),
    .out_vld_r (out_vld_r),
    .out_sop_r (out_sop_r),
    .out_eop_r (out_eop_r),
    .out_err_r (out_err_r),
    .out_dat_r (out_dat_r)
  );

  bind qs_top qs_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .in_rdy    (in_rdy),
    .out_vld_r (out_vld_r),
    .out_sop_r (out_sop_r),
    .out_eop_r (out_eop_r),
    .out_err_r (out_err_r),
    .out_dat_r (out_dat_r),
    .stack_ptr (u_stack.ptr)
  );

  // Any failed assertion ends the run at the next edge
  always @(posedge clk) begin
    if (UUT.u_checker.fail_cnt != 0) begin
      $display("Testbench failed");
      $fatal(1, "the checker reported a failed assertion");
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fill_packet(input int len, input int mode);
    logic [31:0] rnd;
    int          k;
    rnd = next_rand();
    for (k = 0; k < len; k++) begin
      case (mode)
        fill_up: pkt[k] = `QS_W'(k * 3);
        fill_down: pkt[k] = `QS_W'((len - k) * 5);
        fill_same: pkt[k] = rnd[31 -: `QS_W];
        default: begin
          rnd = next_rand();
          // Odd lengths draw from 8 values, so ties are common
          pkt[k] = (len % 2 == 0) ? rnd[31 -: `QS_W] : `QS_W'(rnd[31:29]);
        end
      endcase
    end
  endtask

  task automatic send_packet(input int len);
    logic [31:0] rnd;
    int          idx;
    int          idle;
    idx = 0;
    idle = 0;
    while (idx < len) begin
      rnd = next_rand();
      // About one cycle in four leaves a gap in the valid stream
      if (rnd[31:30] == 2'b00) begin
        in_vld <= 1'b0;
      end else begin
        in_vld <= 1'b1;
        in_sop <= (idx == 0);
        in_eop <= (idx == len - 1);
        in_dat <= pkt[idx];
      end
      @(posedge clk);
      if (in_vld && in_rdy) begin
        idx++;
        idle = 0;
      end else if (idle == timeout_cycles) begin
        $display("Testbench failed");
        $fatal(1, "timeout waiting for in_rdy while sending a packet");
      end else begin
        idle++;
      end
    end
    in_vld <= 1'b0;
    in_sop <= 1'b0;
    in_eop <= 1'b0;
  endtask

  task automatic wait_packet_end();
    int waited;
    waited = 0;
    while (!out_eop_r) begin
      if (waited == timeout_cycles) begin
        $display("Testbench failed");
        $fatal(1, "timeout waiting for the last output beat");
      end
      waited++;
      @(posedge clk);
    end
  endtask

  // A word without a start strobe in idle is dropped by the DUT
  task automatic send_stray();
    int waited;
    waited = 0;
    in_vld <= 1'b1;
    in_sop <= 1'b0;
    in_eop <= 1'b0;
    in_dat <= '1;
    @(posedge clk);
    while (!in_rdy) begin
      if (waited == timeout_cycles) begin
        $display("Testbench failed");
        $fatal(1, "timeout waiting for in_rdy with a stray word");
      end
      waited++;
      @(posedge clk);
    end
    in_vld <= 1'b0;
  endtask

  task automatic run_packet(input int len, input int mode);
    fill_packet(len, mode);
    send_packet(len);
    wait_packet_end();
  endtask

  initial begin
    rst_n = 1'b0;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_dat = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    send_stray();
    // Directed shapes, then an oversized packet followed by normal ones
    run_packet(`QS_N, fill_up);
    run_packet(`QS_N, fill_down);
    run_packet(`QS_N, fill_same);
    run_packet(1, fill_rand);
    run_packet(`QS_N + 3, fill_rand);
    for (n = 0; n < num_random; n++) begin
      run_packet(1 + int'((next_rand() >> 16) % 32'(`QS_N)), fill_rand);
    end
    repeat (4) @(posedge clk);
    if (UUT.u_checker.fail_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "the checker reported a failed assertion");
    end
  end

endmodule

/* dv/qs_checker.sv */
// --------------------------------------------------------------------------
// Bound assertions for the quicksort engine
// Port-level model of accepted input packets, and checks of output order,
// completeness, framing, error beats, reset and range stack depth
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module qs_checker import qs_pkg::*; #(
  parameter int ptr_w = $clog2(idx_w + 2)
) (
  input logic             clk,
  input logic             rst_n,
  input logic             in_vld,
  input logic             in_sop,
  input logic             in_eop,
  input logic [`QS_W-1:0] in_dat,
  input logic             in_rdy,
  input logic             out_vld_r,
  input logic             out_sop_r,
  input logic             out_eop_r,
  input logic             out_err_r,
  input logic [`QS_W-1:0] out_dat_r,
  input logic [ptr_w-1:0] stack_ptr
);

  // Deepest the stack may get with the larger range pushed first
  localparam int stack_depth = idx_w + 1;

  // Failed assertions so far, watched by the testbench
  int fail_cnt = 0;

  // Running totals of the packet being loaded
  logic             in_pkt;
  int               in_cnt;
  logic [`QS_W-1:0] in_sum;
  logic [`QS_W-1:0] in_xor;
  logic             acc;
  int               word_cnt;
  logic [`QS_W-1:0] word_sum;
  logic [`QS_W-1:0] word_xor;

  // Totals of the last complete input packet
  int               pkt_len;
  logic [`QS_W-1:0] pkt_sum;
  logic [`QS_W-1:0] pkt_xor;
  logic             expect_err;

  // Output side of the packet being streamed
  logic             out_busy;
  int               out_cnt;
  logic [`QS_W-1:0] out_sum;
  logic [`QS_W-1:0] out_xor;
  logic [`QS_W-1:0] prev_dat;
  int               beat_cnt;
  logic [`QS_W-1:0] beat_sum;
  logic [`QS_W-1:0] beat_xor;

  // A word counts only from a start strobe up to the end strobe
  assign acc = in_vld & in_rdy & (in_pkt | in_sop);
  assign word_cnt = (in_pkt ? in_cnt : 0) + 1;
  assign word_sum = (in_pkt ? in_sum : '0) + in_dat;
  assign word_xor = (in_pkt ? in_xor : '0) ^ in_dat;

  // Output totals including the beat on the bus now
  assign beat_cnt = (out_sop_r ? 0 : out_cnt) + 1;
  assign beat_sum = (out_sop_r ? '0 : out_sum) + out_dat_r;
  assign beat_xor = (out_sop_r ? '0 : out_xor) ^ out_dat_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_pkt <= 1'b0;
      in_cnt <= 0;
      in_sum <= '0;
      in_xor <= '0;
      pkt_len <= 0;
      pkt_sum <= '0;
      pkt_xor <= '0;
      expect_err <= 1'b0;
      out_busy <= 1'b0;
      out_cnt <= 0;
      out_sum <= '0;
      out_xor <= '0;
      prev_dat <= '0;
    end else begin
      if (acc) begin
        in_pkt <= !in_eop;
        in_cnt <= word_cnt;
        in_sum <= word_sum;
        in_xor <= word_xor;
        // The end strobe closes the packet that the output must match
        if (in_eop) begin
          pkt_len <= word_cnt;
          pkt_sum <= word_sum;
          pkt_xor <= word_xor;
          expect_err <= (word_cnt > `QS_N);
        end
      end
      if (out_vld_r) begin
        out_busy <= !out_eop_r;
        out_cnt <= beat_cnt;
        out_sum <= beat_sum;
        out_xor <= beat_xor;
        prev_dat <= out_dat_r;
      end
    end
  end

  task automatic count_failure(input string what);
    fail_cnt++;
    $error("Fail at %0t ns: %s", $time, what);
  endtask

  // Ready comes up one cycle after reset with the output quiet
  a_reset: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rst_n) |=> in_rdy && !out_vld_r)
    else count_failure("in_rdy low or out_vld_r high after reset");

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_r && !out_sop_r && !out_err_r |-> out_dat_r >= prev_dat)
    else count_failure("output word below the previous one");

  // Length, sum and XOR all match once the last beat is out
  a_complete: assert property (@(posedge clk) disable iff (!rst_n)
    out_eop_r && !out_err_r |->
      beat_cnt == pkt_len && beat_sum == pkt_sum && beat_xor == pkt_xor)
    else count_failure("output packet differs from input in count, sum or XOR");

  a_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    out_sop_r || out_eop_r || out_err_r |-> out_vld_r)
    else count_failure("output strobe without out_vld_r");

  a_sop: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_r |-> out_sop_r == !out_busy)
    else count_failure("out_sop_r not on the first beat of a packet");

  // Beats of one packet are back to back
  a_burst: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_r && !out_eop_r |=> out_vld_r)
    else count_failure("gap inside an output packet");

  a_vld_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_r |-> !in_rdy)
    else count_failure("out_vld_r high while in_rdy high");

  a_rdy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    out_eop_r |=> in_rdy)
    else count_failure("in_rdy not high in the cycle after out_eop_r");

  a_err_beat: assert property (@(posedge clk) disable iff (!rst_n)
    out_err_r |-> out_sop_r && out_eop_r && out_dat_r == '0 && expect_err)
    else count_failure("malformed or unexpected error beat");

  // An oversized packet yields its error beat and nothing else
  a_err_only: assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_r && expect_err |-> out_err_r)
    else count_failure("data beat for an oversized packet");

  a_err_time: assert property (@(posedge clk) disable iff (!rst_n)
    acc && in_eop && word_cnt > `QS_N |=> out_err_r)
    else count_failure("error beat missing after an oversized packet");

  a_stack: assert property (@(posedge clk) disable iff (!rst_n)
    stack_ptr <= ptr_w'(stack_depth))
    else count_failure("range stack deeper than its bound");

endmodule

/* hdl/qs_top.sv */
// --------------------------------------------------------------------------
// Quicksort engine top level
// Connects the control FSM, the stream counter, the word memory and the
// stack of pending ranges to the packet input and output ports
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module qs_top import qs_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Unsorted packet input
  input  logic             in_vld,
  input  logic             in_sop,
  input  logic             in_eop,
  input  logic [`QS_W-1:0] in_dat,
  output logic             in_rdy,
  // Sorted packet output, no back-pressure
  output logic             out_vld_r,
  output logic             out_sop_r,
  output logic             out_eop_r,
  output logic             out_err_r,
  output logic [`QS_W-1:0] out_dat_r
);

  // Counter handshake
  logic             cnt_clr;
  logic             cnt_inc;
  logic             len_load;
  logic [len_w-1:0] cnt_val;
  logic [len_w-1:0] cnt_len;

  // Memory ports
  logic [idx_w-1:0] rd_a_addr;
  logic [idx_w-1:0] rd_b_addr;
  logic [`QS_W-1:0] rd_a_dat;
  logic [`QS_W-1:0] rd_b_dat;
  logic             wr_en;
  logic [idx_w-1:0] wr_addr;
  logic [`QS_W-1:0] wr_dat;

  // Range stack ports
  logic             push;
  logic [idx_w-1:0] push_lo;
  logic [idx_w-1:0] push_hi;
  logic             pop;
  logic [idx_w-1:0] top_lo;
  logic [idx_w-1:0] top_hi;
  logic             empty;

  qs_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_vld    (in_vld),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_dat    (in_dat),
    .in_rdy    (in_rdy),
    .cnt_clr   (cnt_clr),
    .cnt_inc   (cnt_inc),
    .len_load  (len_load),
    .cnt_val   (cnt_val),
    .cnt_len   (cnt_len),
    .rd_a_addr (rd_a_addr),
    .rd_b_addr (rd_b_addr),
    .rd_a_dat  (rd_a_dat),
    .rd_b_dat  (rd_b_dat),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat),
    .push      (push),
    .push_lo   (push_lo),
    .push_hi   (push_hi),
    .pop       (pop),
    .top_lo    (top_lo),
    .top_hi    (top_hi),
    .empty     (empty),
    .out_vld_r (out_vld_r),
    .out_sop_r (out_sop_r),
    .out_eop_r (out_eop_r),
    .out_err_r (out_err_r),
    .out_dat_r (out_dat_r)
  );

  qs_count u_count (
    .clk      (clk),
    .rst_n    (rst_n),
    .cnt_clr  (cnt_clr),
    .cnt_inc  (cnt_inc),
    .len_load (len_load),
    .cnt_val  (cnt_val),
    .cnt_len  (cnt_len)
  );

  qs_mem u_mem (
    .clk       (clk),
    .rd_a_addr (rd_a_addr),
    .rd_a_dat  (rd_a_dat),
    .rd_b_addr (rd_b_addr),
    .rd_b_dat  (rd_b_dat),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_dat    (wr_dat)
  );

  qs_stack u_stack (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push),
    .push_lo (push_lo),
    .push_hi (push_hi),
    .pop     (pop),
    .top_lo  (top_lo),
    .top_hi  (top_hi),
    .empty   (empty)
  );

endmodule

/* hdl/qs_fsm.sv */
// --------------------------------------------------------------------------
// Control FSM of the quicksort engine
// Packet load with overflow detection, iterative Lomuto quicksort over a
// stack of pending ranges, in-order unload and the single error beat
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module qs_fsm import qs_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_vld,
  input  logic             in_sop,
  input  logic             in_eop,
  input  logic [`QS_W-1:0] in_dat,
  output logic             in_rdy,
  output logic             cnt_clr,
  output logic             cnt_inc,
  output logic             len_load,
  input  logic [len_w-1:0] cnt_val,
  input  logic [len_w-1:0] cnt_len,
  output logic [idx_w-1:0] rd_a_addr,
  output logic [idx_w-1:0] rd_b_addr,
  input  logic [`QS_W-1:0] rd_a_dat,
  input  logic [`QS_W-1:0] rd_b_dat,
  output logic             wr_en,
  output logic [idx_w-1:0] wr_addr,
  output logic [`QS_W-1:0] wr_dat,
  output logic             push,
  output logic [idx_w-1:0] push_lo,
  output logic [idx_w-1:0] push_hi,
  output logic             pop,
  input  logic [idx_w-1:0] top_lo,
  input  logic [idx_w-1:0] top_hi,
  input  logic             empty,
  output logic             out_vld_r,
  output logic             out_sop_r,
  output logic             out_eop_r,
  output logic             out_err_r,
  output logic [`QS_W-1:0] out_dat_r
);

  qs_state_t state;

  // Registered ready, so it is low through reset and the whole sort
  logic rdy_q;

  // Current range, store pointer i and scan pointer j
  logic [idx_w-1:0] lo_q;
  logic [idx_w-1:0] hi_q;
  logic [idx_w-1:0] i_q;
  logic [idx_w-1:0] j_q;

  // Pivot value and the first half of a two-cycle swap
  logic [`QS_W-1:0] pivot_q;
  logic [`QS_W-1:0] tmp_q;

  logic take;
  logic load_acc;
  logic full;
  logic err_beat;
  logic last;
  logic less;
  logic scan_end;

  // Sub-range bookkeeping once the pivot position i is known
  logic [idx_w-1:0] left_sz;
  logic [idx_w-1:0] right_sz;
  logic             left_big;
  logic             big_ok;
  logic             sml_ok;
  logic [idx_w-1:0] big_lo;
  logic [idx_w-1:0] big_hi;
  logic [idx_w-1:0] sml_lo;
  logic [idx_w-1:0] sml_hi;

  assign in_rdy = rdy_q;

  assign take = in_vld & rdy_q;
  // In idle only a start strobe opens a packet, stray words are dropped
  assign load_acc = take & ((state == st_load) | ((state == st_idle) & in_sop));
  // Memory already holds N words, so any further word is an overflow
  assign full = (cnt_val == len_w'(`QS_N));
  assign err_beat = take & in_eop & (((state == st_load) & full) | (state == st_drain));
  assign last = (cnt_val == cnt_len - 1'b1);

  assign less = (rd_a_dat < pivot_q);
  assign scan_end = (j_q == hi_q);

  // Left part is lo..i-1 and right part is i+1..hi
  assign left_sz = i_q - lo_q;
  assign right_sz = hi_q - i_q;
  assign left_big = (left_sz >= right_sz);
  assign big_ok = left_big ? (left_sz > idx_w'(1)) : (right_sz > idx_w'(1));
  assign sml_ok = left_big ? (right_sz > idx_w'(1)) : (left_sz > idx_w'(1));
  assign big_lo = left_big ? lo_q : i_q + 1'b1;
  assign big_hi = left_big ? i_q - 1'b1 : hi_q;
  assign sml_lo = left_big ? i_q + 1'b1 : lo_q;
  assign sml_hi = left_big ? hi_q : i_q - 1'b1;

  // Strobes to the counter, memory and stack follow from the state alone
  always_comb begin
    cnt_clr = 1'b0;
    cnt_inc = 1'b0;
    len_load = 1'b0;
    rd_a_addr = j_q;
    rd_b_addr = i_q;
    wr_en = 1'b0;
    wr_addr = i_q;
    wr_dat = rd_a_dat;
    push = 1'b0;
    push_lo = big_lo;
    push_hi = big_hi;
    pop = 1'b0;
    case (state)
      st_idle, st_load: begin
        // Store the word at the running index and latch the length at eop
        if (load_acc && !full) begin
          wr_en = 1'b1;
          wr_addr = cnt_val[idx_w-1:0];
          wr_dat = in_dat;
          cnt_inc = 1'b1;
          len_load = in_eop;
        end
      end
      st_push_all: begin
        // Whole packet is the first range, the counter restarts for unload
        cnt_clr = 1'b1;
        push = (cnt_len > len_w'(1));
        push_lo = '0;
        push_hi = idx_w'(cnt_len - 1'b1);
      end
      st_pop: begin
        // Port B fetches the pivot at the top range's high end
        rd_b_addr = top_hi;
        pop = !empty;
      end
      st_part_scan: begin
        if (scan_end) begin
          // Pivot goes to i, and the larger sub-range is pushed now
          wr_en = 1'b1;
          wr_dat = pivot_q;
          push = big_ok;
        end else if (less && (i_q != j_q)) begin
          // First half of the swap writes a[j] into slot i
          wr_en = 1'b1;
        end
      end
      st_part_swap: begin
        wr_en = 1'b1;
        wr_addr = j_q;
        wr_dat = tmp_q;
      end
      st_part_place: begin
        // Old a[i] lands at hi, and the smaller sub-range goes on top
        wr_en = 1'b1;
        wr_addr = hi_q;
        wr_dat = tmp_q;
        push = sml_ok;
        push_lo = sml_lo;
        push_hi = sml_hi;
      end
      st_unload: begin
        rd_a_addr = cnt_val[idx_w-1:0];
        cnt_clr = last;
        cnt_inc = !last;
      end
      st_err_out: begin
        cnt_clr = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      rdy_q <= 1'b0;
      lo_q <= '0;
      hi_q <= '0;
      i_q <= '0;
      j_q <= '0;
      out_vld_r <= 1'b0;
      out_sop_r <= 1'b0;
      out_eop_r <= 1'b0;
      out_err_r <= 1'b0;
    end else begin
      // Output strobes are single-cycle unless a state drives them again
      out_vld_r <= 1'b0;
      out_sop_r <= 1'b0;
      out_eop_r <= 1'b0;
      out_err_r <= 1'b0;
      // The error beat leaves on the edge of the eop transfer
      if (err_beat) begin
        out_vld_r <= 1'b1;
        out_sop_r <= 1'b1;
        out_eop_r <= 1'b1;
        out_err_r <= 1'b1;
      end
      case (state)
        st_idle: begin
          rdy_q <= 1'b1;
          if (load_acc) begin
            if (in_eop) begin
              rdy_q <= 1'b0;
              state <= st_push_all;
            end else begin
              state <= st_load;
            end
          end
        end
        st_load: begin
          if (load_acc && in_eop) begin
            rdy_q <= 1'b0;
            state <= full ? st_err_out : st_push_all;
          end else if (load_acc && full) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          // Discard the rest of an oversized packet up to its eop
          if (err_beat) begin
            rdy_q <= 1'b0;
            state <= st_err_out;
          end
        end
        st_push_all: begin
          state <= st_pop;
        end
        st_pop: begin
          if (empty) begin
            state <= st_unload;
          end else begin
            lo_q <= top_lo;
            hi_q <= top_hi;
            i_q <= top_lo;
            j_q <= top_lo;
            state <= st_part_scan;
          end
        end
        st_part_scan: begin
          if (scan_end) begin
            state <= st_part_place;
          end else if (less && (i_q == j_q)) begin
            // Element already sits in the store slot
            i_q <= i_q + 1'b1;
            j_q <= j_q + 1'b1;
          end else if (less) begin
            state <= st_part_swap;
          end else begin
            j_q <= j_q + 1'b1;
          end
        end
        st_part_swap: begin
          i_q <= i_q + 1'b1;
          j_q <= j_q + 1'b1;
          state <= st_part_scan;
        end
        st_part_place: begin
          state <= st_pop;
        end
        st_unload: begin
          out_vld_r <= 1'b1;
          out_sop_r <= (cnt_val == '0);
          out_eop_r <= last;
          // Idle raises ready one cycle after the eop beat
          if (last) begin
            state <= st_idle;
          end
        end
        st_err_out: begin
          rdy_q <= 1'b1;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Data path registers
  always_ff @(posedge clk) begin
    if (state == st_pop) begin
      pivot_q <= rd_b_dat;
    end
    // Old a[i] is kept for the second write of a swap or the pivot place
    if (state == st_part_scan) begin
      tmp_q <= rd_b_dat;
    end
    if (state == st_unload) begin
      out_dat_r <= rd_a_dat;
    end else if (err_beat) begin
      out_dat_r <= '0;
    end
  end

endmodule

/* hdl/qs_stack.sv */
// --------------------------------------------------------------------------
// Range stack of the quicksort engine
// LIFO of low and high index pairs still waiting to be partitioned
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module qs_stack import qs_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [idx_w-1:0] push_lo,
  input  logic [idx_w-1:0] push_hi,
  input  logic             pop,
  output logic [idx_w-1:0] top_lo,
  output logic [idx_w-1:0] top_hi,
  output logic             empty
);

  // Smaller range is always sorted first, so log2(N) + 1 entries suffice
  localparam int depth = idx_w + 1;
  localparam int ptr_w = $clog2(depth + 1);

  logic [idx_w-1:0] lo_mem [depth];
  logic [idx_w-1:0] hi_mem [depth];

  // Number of entries held, the top sits one below it
  logic [ptr_w-1:0] ptr;
  logic [ptr_w-1:0] top_ptr;
  logic [ptr_w-1:0] wr_ptr;

  assign empty = (ptr == '0);
  assign top_ptr = empty ? '0 : ptr - 1'b1;
  assign top_lo = lo_mem[top_ptr];
  assign top_hi = hi_mem[top_ptr];

  // Push together with pop replaces the top entry
  assign wr_ptr = pop ? top_ptr : ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (push && !pop) begin
      ptr <= ptr + 1'b1;
    end else if (pop && !push && !empty) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      lo_mem[wr_ptr] <= push_lo;
      hi_mem[wr_ptr] <= push_hi;
    end
  end

endmodule

/* hdl/qs_mem.sv */
// --------------------------------------------------------------------------
// Word memory of the quicksort engine
// Register array with two combinational read ports and one write port
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module qs_mem import qs_pkg::*; (
  input  logic             clk,
  input  logic [idx_w-1:0] rd_a_addr,
  output logic [`QS_W-1:0] rd_a_dat,
  input  logic [idx_w-1:0] rd_b_addr,
  output logic [`QS_W-1:0] rd_b_dat,
  input  logic             wr_en,
  input  logic [idx_w-1:0] wr_addr,
  input  logic [`QS_W-1:0] wr_dat
);

  logic [`QS_W-1:0] mem [`QS_N];

  // Port A serves the scan compare and the unload stream
  assign rd_a_dat = mem[rd_a_addr];

  // Port B serves the pivot fetch and the swap partner
  assign rd_b_dat = mem[rd_b_addr];

  // Reads in the cycle of a write still return the old word
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end
  end

endmodule

/* hdl/qs_count.sv */
// --------------------------------------------------------------------------
// Stream counter of the quicksort engine
// Word index for load and unload, and the latched packet length
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "qs_params.svh"

module qs_count import qs_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cnt_clr,
  input  logic             cnt_inc,
  input  logic             len_load,
  output logic [len_w-1:0] cnt_val,
  output logic [len_w-1:0] cnt_len
);

  // Largest count, one past the last memory index
  localparam logic [len_w-1:0] n_max = len_w'(`QS_N);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_val <= '0;
      cnt_len <= '0;
    end else begin
      // Clear wins so the FSM can restart the index on any state change
      if (cnt_clr) begin
        cnt_val <= '0;
      end else if (cnt_inc && (cnt_val != n_max)) begin
        cnt_val <= cnt_val + 1'b1;
      end
      // Length includes the eop word counted in the same cycle
      if (len_load) begin
        cnt_len <= (cnt_val == n_max) ? n_max : cnt_val + 1'b1;
      end
    end
  end

endmodule

/* hdl/qs_pkg.sv */
// --------------------------------------------------------------------------
// Shared types of the quicksort engine
// Index and length widths, and the state encoding of the control FSM
// --------------------------------------------------------------------------

`include "qs_params.svh"

package qs_pkg;

  // Width of a memory index, also used for the range stack entries
  localparam int idx_w = $clog2(`QS_N);

  // One more bit than an index so that a full packet length fits
  localparam int len_w = idx_w + 1;

  // States of the control FSM, from packet load through sort to unload
  typedef enum logic [3:0] {
    st_idle,
    st_load,
    st_drain,
    st_push_all,
    st_pop,
    st_part_scan,
    st_part_swap,
    st_part_place,
    st_unload,
    st_err_out
  } qs_state_t;

endpackage

/* hdl/qs_params.svh */
// --------------------------------------------------------------------------
// Build-time sizes of the quicksort engine
// Data word width and memory depth, which is the longest packet
// --------------------------------------------------------------------------

`ifndef QS_PARAMS_SVH
`define QS_PARAMS_SVH

// Width of one unsigned data word
`define QS_W 16

// Memory depth in words and therefore the longest packet that is sorted
// Must be a power of two and at least 4
`define QS_N 16

`endif
